//--- Bender.yml
package:
  name: dma_subsystem

sources:
  - stream_pkg.sv
  - bus_pkg.sv
  - beat_packer.sv
  - beat_fifo.sv
  - dma_writer.sv
  - dma_subsystem.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - dma_asserts.sv
      - tb_dma.sv

//--- beat_fifo.sv
// Synchronous payload FIFO
`timescale 1ns/1ps

module beat_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 8
) (
    input  logic     clock,
    input  logic     reset,

    // Write side
    input  payload_t push_data,
    input  logic     push_valid,
    output logic     push_ready,

    // Read side
    output payload_t pop_data,
    output logic     pop_valid,
    input  logic     pop_ready
);

    localparam int ptr_width = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int cnt_width = $clog2(FIFO_DEPTH + 1);

    // Pointers wrap explicitly so that any depth works, not only powers of two
    localparam logic [ptr_width-1:0] last_slot  = ptr_width'(FIFO_DEPTH - 1);
    localparam logic [cnt_width-1:0] full_count = cnt_width'(FIFO_DEPTH);

    payload_t             mem [FIFO_DEPTH];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;
    logic                 push;
    logic                 pop;

    assign push_ready = (count != full_count);
    assign pop_valid  = (count != '0);
    assign push       = push_valid && push_ready;
    assign pop        = pop_valid && pop_ready;

    // The head entry is presented directly, so a push shows up one cycle later
    assign pop_data   = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end

            if (pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end

            // A push and a pop together leave the occupancy unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- beat_packer.sv
// Stream word to beat packer
`timescale 1ns/1ps

module beat_packer
    import stream_pkg::*;
(
    input  logic         clock,
    input  logic         reset,

    // Word stream from the source
    input  stream_word_t in_word,
    input  logic         in_valid,
    output logic         in_ready,

    // Beat stream towards the FIFO
    output stream_beat_t pack_beat,
    output logic         pack_valid,
    input  logic         pack_ready
);

    // High while the low half of the next beat already holds a word
    logic                  half_full;

    // Keeps the input closed until the first cycle after reset
    logic                  armed;

    logic [word_width-1:0] low_word;
    logic                  accept;
    logic                  completes;

    // A pending beat blocks new words unless it leaves in this same cycle
    assign in_ready  = armed && (!pack_valid || pack_ready);
    assign accept    = in_valid && in_ready;

    // The second word of a pair closes the beat, and so does a last word
    // that lands in the low half
    assign completes = half_full || in_word.last;

    always_ff @(posedge clock) begin
        if (!reset) begin
            armed      <= 1'b0;
            half_full  <= 1'b0;
            pack_valid <= 1'b0;
        end else begin
            armed <= 1'b1;

            if (accept && completes) begin
                pack_valid <= 1'b1;
            end else if (pack_ready) begin
                pack_valid <= 1'b0;
            end

            if (accept) begin
                half_full <= !completes;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            if (half_full) begin
                pack_beat.data <= {in_word.data, low_word};
                pack_beat.last <= in_word.last;
            end else if (in_word.last) begin
                // Odd word count, so the high half is padded with zeros
                pack_beat.data <= {{word_width{1'b0}}, in_word.data};
                pack_beat.last <= 1'b1;
            end else begin
                low_word <= in_word.data;
            end
        end
    end

endmodule

//--- bus_pkg.sv
// Memory write bus types
package bus_pkg;

    // Byte address width on the write bus
    localparam int addr_width = 64;

    // Data width of the write channel
    localparam int data_width = 128;

    // One strobe bit per data byte
    localparam int strb_width = data_width / 8;

    // Width of the response code
    localparam int resp_width = 2;

    // Response codes that the writer and the memory agree on
    localparam logic [resp_width-1:0] resp_okay   = 2'b00;
    localparam logic [resp_width-1:0] resp_slverr = 2'b10;

    // Address channel payload, one single-beat burst per transfer
    typedef struct packed {
        logic [addr_width-1:0] addr;
    } wr_addr_t;

    // Data channel payload
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
    } wr_data_t;

    // Response channel payload
    typedef struct packed {
        logic [resp_width-1:0] resp;
    } wr_resp_t;

endpackage

//--- dma_asserts.sv
// DMA subsystem protocol assertions
`timescale 1ns/1ps

module dma_asserts
    import stream_pkg::*;
    import bus_pkg::*;
(
    input logic                  clock,
    input logic                  reset,
    input logic                  start,
    input logic [addr_width-1:0] base_addr,
    input logic                  in_ready,
    input logic                  pack_valid,
    input logic                  fifo_valid,
    input wr_addr_t              aw,
    input logic                  aw_valid,
    input logic                  aw_ready,
    input wr_data_t              w,
    input logic                  w_valid,
    input logic                  w_ready,
    input logic                  b_ready,
    input logic                  done
);

    // Number of assertion failures so far
    int                    fail_count = 0;
    logic                  busy;
    logic [addr_width-1:0] base_q;

    // Mirrors the base address that the writer latches when it accepts start
    always_ff @(posedge clock) begin
        if (!reset) begin
            busy <= 1'b0;
        end else if (start && !busy) begin
            busy   <= 1'b1;
            base_q <= base_addr;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    task automatic note_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    aw_hold: assert property (@(posedge clock) disable iff (!reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else note_failure("address channel changed while waiting for aw_ready");

    w_hold: assert property (@(posedge clock) disable iff (!reset)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else note_failure("data channel changed while waiting for w_ready");

    // Every beat address sits a whole number of beats above the base
    aw_step: assert property (@(posedge clock) disable iff (!reset)
        aw_valid |-> aw.addr >= base_q && ((aw.addr - base_q) % beat_bytes) == 0)
        else note_failure("aw.addr is not a beat step above the base address");

    w_strobe: assert property (@(posedge clock) disable iff (!reset)
        w_valid |-> w.strb == '1)
        else note_failure("write strobe is not all ones");

    reset_quiet: assert property (@(posedge clock) $rose(reset) |->
        !pack_valid && !fifo_valid && !aw_valid && !w_valid && !b_ready && !in_ready && !done)
        else note_failure("outputs were not idle in the first cycle after reset");

    done_alone: assert property (@(posedge clock) disable iff (!reset)
        done |-> !aw_valid && !w_valid)
        else note_failure("done was high while a write channel was still valid");

endmodule

//--- dma_subsystem.sv
// Stream to memory DMA top level
`timescale 1ns/1ps

module dma_subsystem
    import stream_pkg::*;
    import bus_pkg::*;
#(
    parameter int FIFO_DEPTH  = 8,
    parameter int COUNT_WIDTH = 16
) (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  start,
    input  logic [addr_width-1:0] base_addr,

    input  stream_word_t          in_word,
    input  logic                  in_valid,
    output logic                  in_ready,

    output wr_addr_t              aw,
    output logic                  aw_valid,
    input  logic                  aw_ready,
    output wr_data_t              w,
    output logic                  w_valid,
    input  logic                  w_ready,
    input  wr_resp_t              b,
    input  logic                  b_valid,
    output logic                  b_ready,

    output logic                  done,
    output logic                  error
);

    stream_beat_t pack_beat;
    logic         pack_valid;
    logic         pack_ready;

    stream_beat_t fifo_beat;
    logic         fifo_valid;
    logic         fifo_ready;

    beat_packer packer0 (
        .clock      (clock),
        .reset      (reset),
        .in_word    (in_word),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .pack_beat  (pack_beat),
        .pack_valid (pack_valid),
        .pack_ready (pack_ready)
    );

    beat_fifo #(
        .payload_t  (stream_beat_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clock      (clock),
        .reset      (reset),
        .push_data  (pack_beat),
        .push_valid (pack_valid),
        .push_ready (pack_ready),
        .pop_data   (fifo_beat),
        .pop_valid  (fifo_valid),
        .pop_ready  (fifo_ready)
    );

    dma_writer #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) writer0 (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .base_addr  (base_addr),
        .beat       (fifo_beat),
        .beat_valid (fifo_valid),
        .beat_ready (fifo_ready),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b          (b),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .done       (done),
        .error      (error)
    );

endmodule

//--- dma_writer.sv
// Beat to memory write engine
`timescale 1ns/1ps

module dma_writer
    import stream_pkg::*;
    import bus_pkg::*;
#(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                  clock,
    input  logic                  reset,

    // Transfer control
    input  logic                  start,
    input  logic [addr_width-1:0] base_addr,

    // Buffered beats from the FIFO
    input  stream_beat_t          beat,
    input  logic                  beat_valid,
    output logic                  beat_ready,

    // Address channel
    output wr_addr_t              aw,
    output logic                  aw_valid,
    input  logic                  aw_ready,

    // Data channel
    output wr_data_t              w,
    output logic                  w_valid,
    input  logic                  w_ready,

    // Response channel
    input  wr_resp_t              b,
    input  logic                  b_valid,
    output logic                  b_ready,

    // Completion
    output logic                  done,
    output logic                  error
);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_send,
        st_wait_resp
    } state_t;

    state_t                 state;
    logic [addr_width-1:0]  base_q;
    logic [COUNT_WIDTH-1:0] beat_count;
    logic                   last_q;
    logic [addr_width-1:0]  beat_addr;
    logic                   pop;
    logic                   b_done;

    // Each beat lands beat_bytes above the previous one
    assign beat_addr  = base_q + (addr_width'(beat_count) << beat_shift);

    assign beat_ready = (state == st_fetch);
    assign pop        = beat_valid && beat_ready;

    // The response is taken only once both address and data have gone out
    assign b_ready    = (state == st_wait_resp) && !aw_valid && !w_valid;
    assign b_done     = b_valid && b_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= st_idle;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
            done       <= 1'b0;
            error      <= 1'b0;
            beat_count <= '0;
        end else begin
            done <= 1'b0;

            case (state)
                st_idle: begin
                    if (start) begin
                        error      <= 1'b0;
                        beat_count <= '0;
                        state      <= st_fetch;
                    end
                end

                st_fetch: begin
                    if (pop) begin
                        state <= st_send;
                    end
                end

                // Payloads were loaded at the pop, so both channels open together
                st_send: begin
                    aw_valid <= 1'b1;
                    w_valid  <= 1'b1;
                    state    <= st_wait_resp;
                end

                st_wait_resp: begin
                    // The two channels may complete in either order
                    if (aw_valid && aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_valid && w_ready) begin
                        w_valid <= 1'b0;
                    end

                    if (b_done) begin
                        if (b.resp != resp_okay) begin
                            error <= 1'b1;
                        end
                        if (last_q) begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end else begin
                            beat_count <= beat_count + 1'b1;
                            state      <= st_fetch;
                        end
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_idle && start) begin
            base_q <= base_addr;
        end

        if (pop) begin
            aw.addr <= beat_addr;
            w.data  <= beat.data;
            w.strb  <= '1;
            last_q  <= beat.last;
        end
    end

endmodule

//--- sources.f
stream_pkg.sv
bus_pkg.sv
beat_packer.sv
beat_fifo.sv
dma_writer.sv
dma_subsystem.sv
tb_clock_gen.sv
dma_asserts.sv
tb_dma.sv

//--- stream_pkg.sv
// Stream word and beat types
package stream_pkg;

    // Width of one word on the input stream
    localparam int word_width = 64;

    // Width of one packed beat, two stream words side by side
    localparam int beat_width = 128;

    // Bytes covered by one beat in memory, which is also the address step
    localparam int beat_bytes = beat_width / 8;

    // Shift that turns a beat index into a byte offset
    localparam int beat_shift = $clog2(beat_bytes);

    // One word as it arrives from the source
    typedef struct packed {
        logic [word_width-1:0] data;
        logic                  last;
    } stream_word_t;

    // One beat as it leaves the packer and passes through the FIFO.
    // The first word of a pair sits in the low half
    typedef struct packed {
        logic [beat_width-1:0] data;
        logic                  last;
    } stream_beat_t;

endpackage

//--- tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 4
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // Reset is active low and is released just after a rising edge
    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b1;
    end

endmodule

//--- tb_dma.sv
// DMA subsystem testbench
`timescale 1ns/1ps

module tb_dma
    import stream_pkg::*;
    import bus_pkg::*;
();

    localparam int clock_period = 20;
    localparam int drive_delay  = 2;
    localparam int fifo_depth   = 8;
    // 40 cycles per word over all four transfers, plus room for the held-off phase
    localparam int watchdog_cycles = (12 + 7 + 6 + 24) * 40 + 500;

    logic                  clock;
    logic                  reset;
    logic                  start;
    logic [addr_width-1:0] base_addr;
    stream_word_t          in_word;
    logic                  in_valid;
    logic                  in_ready;
    wr_addr_t              aw;
    logic                  aw_valid;
    logic                  aw_ready;
    wr_data_t              w;
    logic                  w_valid;
    logic                  w_ready;
    wr_resp_t              b;
    logic                  b_valid;
    logic                  b_ready;
    logic                  done;
    logic                  error;

    // Memory model contents, keyed by byte address
    logic [beat_width-1:0] mem_data [logic [addr_width-1:0]];
    logic [word_width-1:0] words [$];
    logic                  hold_aw;
    logic                  err_enable;
    logic [addr_width-1:0] err_addr;
    int                    done_count;
    int                    words_sent;

    tb_clock_gen #(.period(clock_period), .reset_cycles(4)) clock_gen0 (.clock, .reset);

    dma_subsystem #(.FIFO_DEPTH(fifo_depth), .COUNT_WIDTH(16)) dut0 (.*);

    bind dma_subsystem dma_asserts asserts0 (.*);

    task automatic fail_check(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "check failed");
    endtask

    // Single-outstanding write slave with random ready and response delays
    task automatic run_memory();
        logic                  have_aw;
        logic                  have_w;
        logic                  b_fire;
        logic [addr_width-1:0] addr_q;
        logic [beat_width-1:0] data_q;
        have_aw = 1'b0;
        have_w  = 1'b0;
        b_fire  = 1'b0;
        forever begin
            @(posedge clock);
            #drive_delay;
            aw_ready = aw_valid && !have_aw && !hold_aw && ($urandom_range(0, 2) == 0);
            w_ready  = w_valid && !have_w && ($urandom_range(0, 2) == 0);
            if (aw_ready) begin
                have_aw = 1'b1;
                addr_q  = aw.addr;
            end
            if (w_ready) begin
                have_w = 1'b1;
                data_q = w.data;
            end
            if (b_fire) begin
                b_valid = 1'b0;
                have_aw = 1'b0;
                have_w  = 1'b0;
                b_fire  = 1'b0;
            end else begin
                if (!b_valid && have_aw && have_w && !aw_valid && !w_valid
                        && ($urandom_range(0, 2) == 0)) begin
                    mem_data[addr_q] = data_q;
                    b.resp  = (err_enable && addr_q == err_addr) ? resp_slverr : resp_okay;
                    b_valid = 1'b1;
                end
                b_fire = b_valid && b_ready;
            end
        end
    endtask

    task automatic send_words(input int n);
        logic taken;
        for (int i = 0; i < n; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                in_valid = 1'b0;
                @(posedge clock);
                #drive_delay;
            end
            in_word.data = words[i];
            in_word.last = (i == n - 1);
            in_valid     = 1'b1;
            taken        = 1'b0;
            while (!taken) begin
                taken = in_ready;
                @(posedge clock);
                #drive_delay;
            end
            words_sent++;
        end
        in_valid = 1'b0;
    endtask

    task automatic run_transfer(input int n, input logic [addr_width-1:0] base,
                                input logic expect_error, input logic press);
        logic [beat_width-1:0] expected;
        logic [addr_width-1:0] addr;
        logic                  error_seen;
        int                    stalled;
        mem_data.delete();
        words.delete();
        for (int i = 0; i < n; i++) begin
            words.push_back({$urandom, $urandom});
        end
        done_count = 0;
        words_sent = 0;
        hold_aw    = press;
        start      = 1'b1;
        base_addr  = base;
        @(posedge clock);
        #drive_delay;
        start = 1'b0;
        fork
            send_words(n);
            begin
                while (!done) begin
                    @(posedge clock);
                    #drive_delay;
                end
                error_seen = error;
            end
            begin
                stalled = 0;
                while (press && stalled < 12) begin
                    @(posedge clock);
                    #drive_delay;
                    stalled = (in_valid && !in_ready) ? stalled + 1 : 0;
                end
                // The writer holds one beat, the FIFO fifo_depth and the packer one more
                assert (!press || words_sent == 2 * (fifo_depth + 2))
                    else fail_check($sformatf("MISMATCH words_sent got 0x%h expected 0x%h",
                                              words_sent, 2 * (fifo_depth + 2)));
                hold_aw = 1'b0;
            end
        join
        repeat (3) @(posedge clock);
        #drive_delay;
        assert (done_count == 1) else fail_check("done did not pulse exactly once");
        assert (error_seen == expect_error)
            else fail_check($sformatf("MISMATCH error got 0x%h expected 0x%h",
                                      error_seen, expect_error));
        assert (mem_data.num() == (n + 1) / 2) else fail_check("wrong number of beats written");
        for (int k = 0; k < (n + 1) / 2; k++) begin
            addr     = base + addr_width'(k * beat_bytes);
            expected = {((2 * k + 1 < n) ? words[2 * k + 1] : {word_width{1'b0}}), words[2 * k]};
            assert (mem_data.exists(addr))
                else fail_check($sformatf("no write reached address 0x%h", addr));
            assert (mem_data[addr] == expected)
                else fail_check($sformatf("MISMATCH mem_data[0x%h] got 0x%h expected 0x%h",
                                          addr, mem_data[addr], expected));
        end
    endtask

    always @(negedge clock) begin
        if (done) begin
            done_count++;
        end
        if (dut0.asserts0.fail_count != 0) begin
            fail_check("a protocol assertion on the DUT failed");
        end
    end

    initial begin
        #(watchdog_cycles * clock_period);
        fail_check("watchdog expired before the transfers finished");
    end

    initial begin
        start      = 1'b0;
        base_addr  = '0;
        in_word    = '0;
        in_valid   = 1'b0;
        aw_ready   = 1'b0;
        w_ready    = 1'b0;
        b          = '0;
        b_valid    = 1'b0;
        hold_aw    = 1'b0;
        err_enable = 1'b0;
        err_addr   = '0;
        void'($urandom(32'hac80763f));
        fork
            run_memory();
        join_none
        @(posedge reset);
        @(posedge clock);
        #drive_delay;
        run_transfer(12, 64'h0000_0000_0000_1000, 1'b0, 1'b0);
        run_transfer(7, 64'h0000_0001_0000_2000, 1'b0, 1'b0);
        // Second beat of this transfer gets a slave error and the third must still follow
        err_enable = 1'b1;
        err_addr   = 64'h0000_0000_0000_4010;
        run_transfer(6, 64'h0000_0000_0000_4000, 1'b1, 1'b0);
        err_enable = 1'b0;
        run_transfer(24, 64'h0000_0000_0000_3000, 1'b0, 1'b1);
        if (dut0.asserts0.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule
